/* frontend_cfg.svh */
`ifndef FRONTEND_CFG_SVH
`define FRONTEND_CFG_SVH

// lane count and queue depth are powers of two.
`define NUM_DECODE_LANES 2
`define UOPQ_DEPTH 2

`define XLEN 32 // data and pc width.
`define UOP_W 4 // uop code width.

`endif

/* rv_decode_pkg.sv */
`default_nettype none

`include "frontend_cfg.svh"

package rv_decode_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_fmt_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } rv_s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } rv_b_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_j_fmt_t;

    // one instruction word, seen through each encoding format.
    typedef union packed {
        logic [31:0] raw;
        rv_r_fmt_t   r;
        rv_i_fmt_t   i;
        rv_s_fmt_t   s;
        rv_b_fmt_t   b;
        rv_u_fmt_t   u;
        rv_j_fmt_t   j;
    } rv_instr_t;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    localparam logic [`UOP_W-1:0] UOP_ADD     = `UOP_W'd1;
    localparam logic [`UOP_W-1:0] UOP_SUB     = `UOP_W'd2;
    localparam logic [`UOP_W-1:0] UOP_ADDI    = `UOP_W'd3;
    localparam logic [`UOP_W-1:0] UOP_LW      = `UOP_W'd4;
    localparam logic [`UOP_W-1:0] UOP_SW      = `UOP_W'd5;
    localparam logic [`UOP_W-1:0] UOP_BEQ     = `UOP_W'd6;
    localparam logic [`UOP_W-1:0] UOP_LUI     = `UOP_W'd7;
    localparam logic [`UOP_W-1:0] UOP_JAL     = `UOP_W'd8;
    localparam logic [`UOP_W-1:0] UOP_EBREAK  = `UOP_W'd9;
    localparam logic [`UOP_W-1:0] UOP_ILLEGAL = `UOP_W'd15;

    function automatic logic [`UOP_W-1:0] decode_uop(input rv_instr_t instr);
        logic [`UOP_W-1:0] op;
        op = UOP_ILLEGAL;
        case (instr.r.opcode)
            OPC_OP: begin
                if (instr.r.funct3 == 3'b000 && instr.r.funct7 == 7'b0000000)
                    op = UOP_ADD;
                else if (instr.r.funct3 == 3'b000 && instr.r.funct7 == 7'b0100000)
                    op = UOP_SUB;
            end
            OPC_OP_IMM: if (instr.i.funct3 == 3'b000) op = UOP_ADDI;
            OPC_LOAD:   if (instr.i.funct3 == 3'b010) op = UOP_LW;
            OPC_STORE:  if (instr.s.funct3 == 3'b010) op = UOP_SW;
            OPC_BRANCH: if (instr.b.funct3 == 3'b000) op = UOP_BEQ;
            OPC_LUI:    op = UOP_LUI;
            OPC_JAL:    op = UOP_JAL;
            OPC_SYSTEM: if (instr.raw == EBREAK_WORD) op = UOP_EBREAK;
            default:    op = UOP_ILLEGAL;
        endcase
        return op;
    endfunction

    // immediate per format, sign extended; zero for uops without one.
    function automatic logic [`XLEN-1:0] decode_imm(input rv_instr_t instr,
                                                    input logic [`UOP_W-1:0] op);
        logic [`XLEN-1:0] imm;
        imm = '0;
        case (op)
            UOP_ADDI, UOP_LW: imm = `XLEN'($signed(instr.i.imm11_0));
            UOP_SW:  imm = `XLEN'($signed({instr.s.imm11_5, instr.s.imm4_0}));
            UOP_BEQ: imm = `XLEN'($signed({instr.b.imm12, instr.b.imm11,
                                            instr.b.imm10_5, instr.b.imm4_1, 1'b0}));
            UOP_LUI: imm = `XLEN'({instr.u.imm31_12, 12'h000});
            UOP_JAL: imm = `XLEN'($signed({instr.j.imm20, instr.j.imm19_12,
                                            instr.j.imm11, instr.j.imm10_1, 1'b0}));
            default: imm = '0;
        endcase
        return imm;
    endfunction

    function automatic logic uses_rd(input logic [`UOP_W-1:0] op);
        return op inside {UOP_ADD, UOP_SUB, UOP_ADDI, UOP_LW, UOP_LUI, UOP_JAL};
    endfunction

endpackage

`default_nettype wire

/* decode_dispatch.sv */
`default_nettype none
`timescale 1ns/1ps

`include "frontend_cfg.svh"

module decode_dispatch (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,
    input  logic                          fetch_valid,
    input  logic [`XLEN-1:0]              fetch_pc,
    input  logic [31:0]                   fetch_instr,
    output logic                          fetch_ready,
    input  logic [`NUM_DECODE_LANES-1:0]  lane_ready,
    input  logic [`NUM_DECODE_LANES-1:0]  lane_ebreak,
    output logic [`NUM_DECODE_LANES-1:0]  lane_push,
    output logic [`XLEN-1:0]              lane_pc,
    output rv_decode_pkg::rv_instr_t      lane_instr
);

    localparam int LANE_W = (`NUM_DECODE_LANES > 1) ? $clog2(`NUM_DECODE_LANES) : 1;
    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`NUM_DECODE_LANES - 1);

    logic [LANE_W-1:0] wr_lane;
    logic              stopped;
    logic              running; // low until the cycle after reset.
    logic              accept;

    assign fetch_ready = lane_ready[wr_lane] & running & ~stopped & ~flush;
    assign accept      = fetch_valid & fetch_ready;

    assign lane_pc    = fetch_pc;
    assign lane_instr = fetch_instr;

    always_comb begin
        lane_push          = '0;
        lane_push[wr_lane] = accept;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_lane <= '0;
            stopped <= 1'b0;
        end else begin
            if (accept) begin
                wr_lane <= (wr_lane == LAST_LANE) ? '0 : wr_lane + 1'b1;
            end
            if (|lane_ebreak) begin
                stopped <= 1'b1; // held until flush.
            end
        end
    end

    a_push_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(lane_push))
        else $error("lane_push not one-hot");

endmodule

`default_nettype wire

/* decode_lane.sv */
`default_nettype none
`timescale 1ns/1ps

`include "frontend_cfg.svh"

module decode_lane (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     push,
    input  logic [`XLEN-1:0]         pc,
    input  rv_decode_pkg::rv_instr_t instr,
    input  logic                     pop,
    output logic                     ready,
    output logic                     ebreak_pushed,
    output logic                     q_valid,
    output logic [`UOP_W-1:0]        q_op,
    output logic [4:0]               q_rd,
    output logic [4:0]               q_rs1,
    output logic [4:0]               q_rs2,
    output logic [`XLEN-1:0]         q_imm,
    output logic [`XLEN-1:0]         q_pc
);

    import rv_decode_pkg::*;

    localparam int PTR_W = (`UOPQ_DEPTH > 1) ? $clog2(`UOPQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(`UOPQ_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(`UOPQ_DEPTH - 1);

    logic [`UOP_W-1:0] dec_op;
    logic [4:0]        dec_rd;
    logic [4:0]        dec_rs1;
    logic [4:0]        dec_rs2;
    logic [`XLEN-1:0]  dec_imm;

    logic [`UOP_W-1:0] mem_op  [`UOPQ_DEPTH];
    logic [4:0]        mem_rd  [`UOPQ_DEPTH];
    logic [4:0]        mem_rs1 [`UOPQ_DEPTH];
    logic [4:0]        mem_rs2 [`UOPQ_DEPTH];
    logic [`XLEN-1:0]  mem_imm [`UOPQ_DEPTH];
    logic [`XLEN-1:0]  mem_pc  [`UOPQ_DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    always_comb begin
        dec_op  = decode_uop(instr);
        dec_imm = decode_imm(instr, dec_op);
        dec_rd  = uses_rd(dec_op) ? instr.r.rd : 5'd0;
        dec_rs1 = 5'd0;
        dec_rs2 = 5'd0;
        case (dec_op)
            UOP_ADD, UOP_SUB: begin
                dec_rs1 = instr.r.rs1;
                dec_rs2 = instr.r.rs2;
            end
            UOP_SW: begin
                dec_rs1 = instr.s.rs1;
                dec_rs2 = instr.s.rs2;
            end
            UOP_BEQ: begin
                dec_rs1 = instr.b.rs1;
                dec_rs2 = instr.b.rs2;
            end
            UOP_ADDI, UOP_LW: dec_rs1 = instr.i.rs1;
            default: ; // u, j and system carry no source registers.
        endcase
    end

    assign ebreak_pushed = push & (dec_op == UOP_EBREAK);

    assign ready   = (count != CNT_W'(`UOPQ_DEPTH));
    assign q_valid = (count != '0);

    assign q_op  = mem_op[rd_ptr];
    assign q_rd  = mem_rd[rd_ptr];
    assign q_rs1 = mem_rs1[rd_ptr];
    assign q_rs2 = mem_rs2[rd_ptr];
    assign q_imm = mem_imm[rd_ptr];
    assign q_pc  = mem_pc[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem_op[wr_ptr]  <= dec_op;
            mem_rd[wr_ptr]  <= dec_rd;
            mem_rs1[wr_ptr] <= dec_rs1;
            mem_rs2[wr_ptr] <= dec_rs2;
            mem_imm[wr_ptr] <= dec_imm;
            mem_pc[wr_ptr]  <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        push |-> ready)
        else $error("push into full uop queue");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> q_valid)
        else $error("pop from empty uop queue");

endmodule

`default_nettype wire

/* uop_collect.sv */
`default_nettype none
`timescale 1ns/1ps

`include "frontend_cfg.svh"

module uop_collect (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       flush,
    input  logic [`NUM_DECODE_LANES-1:0]               q_valid,
    input  logic [`NUM_DECODE_LANES-1:0][`UOP_W-1:0]   q_op,
    input  logic [`NUM_DECODE_LANES-1:0][4:0]          q_rd,
    input  logic [`NUM_DECODE_LANES-1:0][4:0]          q_rs1,
    input  logic [`NUM_DECODE_LANES-1:0][4:0]          q_rs2,
    input  logic [`NUM_DECODE_LANES-1:0][`XLEN-1:0]    q_imm,
    input  logic [`NUM_DECODE_LANES-1:0][`XLEN-1:0]    q_pc,
    output logic [`NUM_DECODE_LANES-1:0]               q_pop,
    input  logic                                       uop_ready,
    output logic                                       uop_valid,
    output logic [`UOP_W-1:0]                          uop_op,
    output logic [4:0]                                 uop_rd,
    output logic [4:0]                                 uop_rs1,
    output logic [4:0]                                 uop_rs2,
    output logic [`XLEN-1:0]                           uop_imm,
    output logic [`XLEN-1:0]                           uop_pc
);

    import rv_decode_pkg::*;

    localparam int LANE_W = (`NUM_DECODE_LANES > 1) ? $clog2(`NUM_DECODE_LANES) : 1;
    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`NUM_DECODE_LANES - 1);

    logic [LANE_W-1:0] rd_lane; // follows the dispatcher's order.
    logic              handshake;

    assign uop_valid = q_valid[rd_lane] & ~flush; // nuked uops are not offered.
    assign uop_op    = q_op[rd_lane];
    assign uop_rd    = q_rd[rd_lane];
    assign uop_rs1   = q_rs1[rd_lane];
    assign uop_rs2   = q_rs2[rd_lane];
    assign uop_imm   = q_imm[rd_lane];
    assign uop_pc    = q_pc[rd_lane];

    assign handshake = uop_valid & uop_ready;

    always_comb begin
        q_pop          = '0;
        q_pop[rd_lane] = handshake;
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_lane <= '0;
        end else if (handshake) begin
            rd_lane <= (rd_lane == LAST_LANE) ? '0 : rd_lane + 1'b1;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        uop_valid && !uop_ready && !flush |=>
            flush || (uop_valid && $stable(uop_op) && $stable(uop_rd) &&
                      $stable(uop_rs1) && $stable(uop_rs2) &&
                      $stable(uop_imm) && $stable(uop_pc)))
        else $error("uop output changed under back-pressure");

    // nothing is fetched behind an EBREAK, so the stream goes quiet after it.
    a_quiet_after_ebreak: assert property (@(posedge clk) disable iff (reset)
        handshake && uop_op == UOP_EBREAK |=> !uop_valid)
        else $error("uop issued after EBREAK");

endmodule

`default_nettype wire

/* decode_frontend_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "frontend_cfg.svh"

module decode_frontend_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                fetch_valid,
    input  logic [`XLEN-1:0]    fetch_pc,
    input  logic [31:0]         fetch_instr,
    output logic                fetch_ready,
    output logic                uop_valid,
    output logic [`UOP_W-1:0]   uop_op,
    output logic [4:0]          uop_rd,
    output logic [4:0]          uop_rs1,
    output logic [4:0]          uop_rs2,
    output logic [`XLEN-1:0]    uop_imm,
    output logic [`XLEN-1:0]    uop_pc,
    input  logic                uop_ready
);

    logic [`NUM_DECODE_LANES-1:0]             lane_push;
    logic [`NUM_DECODE_LANES-1:0]             lane_ready;
    logic [`NUM_DECODE_LANES-1:0]             lane_ebreak;
    logic [`XLEN-1:0]                         lane_pc;
    rv_decode_pkg::rv_instr_t                 lane_instr;

    logic [`NUM_DECODE_LANES-1:0]             q_valid;
    logic [`NUM_DECODE_LANES-1:0]             q_pop;
    logic [`NUM_DECODE_LANES-1:0][`UOP_W-1:0] q_op;
    logic [`NUM_DECODE_LANES-1:0][4:0]        q_rd;
    logic [`NUM_DECODE_LANES-1:0][4:0]        q_rs1;
    logic [`NUM_DECODE_LANES-1:0][4:0]        q_rs2;
    logic [`NUM_DECODE_LANES-1:0][`XLEN-1:0]  q_imm;
    logic [`NUM_DECODE_LANES-1:0][`XLEN-1:0]  q_pc;

    decode_dispatch u_decode_dispatch (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .fetch_ready (fetch_ready),
        .lane_ready  (lane_ready),
        .lane_ebreak (lane_ebreak),
        .lane_push   (lane_push),
        .lane_pc     (lane_pc),
        .lane_instr  (lane_instr)
    );

    for (genvar g = 0; g < `NUM_DECODE_LANES; g++) begin : g_lane
        decode_lane u_decode_lane (
            .clk           (clk),
            .reset         (reset),
            .flush         (flush),
            .push          (lane_push[g]),
            .pc            (lane_pc),
            .instr         (lane_instr),
            .pop           (q_pop[g]),
            .ready         (lane_ready[g]),
            .ebreak_pushed (lane_ebreak[g]),
            .q_valid       (q_valid[g]),
            .q_op          (q_op[g]),
            .q_rd          (q_rd[g]),
            .q_rs1         (q_rs1[g]),
            .q_rs2         (q_rs2[g]),
            .q_imm         (q_imm[g]),
            .q_pc          (q_pc[g])
        );
    end

    uop_collect u_uop_collect (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .q_valid   (q_valid),
        .q_op      (q_op),
        .q_rd      (q_rd),
        .q_rs1     (q_rs1),
        .q_rs2     (q_rs2),
        .q_imm     (q_imm),
        .q_pc      (q_pc),
        .q_pop     (q_pop),
        .uop_ready (uop_ready),
        .uop_valid (uop_valid),
        .uop_op    (uop_op),
        .uop_rd    (uop_rd),
        .uop_rs1   (uop_rs1),
        .uop_rs2   (uop_rs2),
        .uop_imm   (uop_imm),
        .uop_pc    (uop_pc)
    );

endmodule

`default_nettype wire

/* tb_decode_frontend.sv */
`default_nettype none
`timescale 1ns/1ps

`include "frontend_cfg.svh"

module tb_decode_frontend;

    import rv_decode_pkg::*;

    localparam int EXP_W          = `UOP_W + 15 + 2 * `XLEN;
    localparam int CAP            = `NUM_DECODE_LANES * `UOPQ_DEPTH;
    localparam int TIMEOUT_CYCLES = 4000;

    logic              clk;
    logic              reset;
    logic              flush;
    logic              fetch_valid;
    logic [`XLEN-1:0]  fetch_pc;
    logic [31:0]       fetch_instr;
    logic              fetch_ready;
    logic              uop_valid;
    logic [`UOP_W-1:0] uop_op;
    logic [4:0]        uop_rd;
    logic [4:0]        uop_rs1;
    logic [4:0]        uop_rs2;
    logic [`XLEN-1:0]  uop_imm;
    logic [`XLEN-1:0]  uop_pc;
    logic              uop_ready;

    logic [EXP_W-1:0]  got;
    logic [EXP_W-1:0]  exp_q[$];       // uops still owed by the DUT, oldest first.
    logic [EXP_W-1:0]  exp_head;
    int                exp_count;
    int                cycles;
    logic              seen_fetch;
    logic              stop_seen;
    logic [31:0]       rng;
    logic [`XLEN-1:0]  pc_next;
    logic              ready_random;

    decode_frontend_top u_decode_frontend_top (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .fetch_ready (fetch_ready),
        .uop_valid   (uop_valid),
        .uop_op      (uop_op),
        .uop_rd      (uop_rd),
        .uop_rs1     (uop_rs1),
        .uop_rs2     (uop_rs2),
        .uop_imm     (uop_imm),
        .uop_pc      (uop_pc),
        .uop_ready   (uop_ready)
    );

    assign got = {uop_op, uop_rd, uop_rs1, uop_rs2, uop_imm, uop_pc};

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // rv32i reference decode, fields not used by the uop stay zero.
    function automatic logic [EXP_W-1:0] expected_uop(input logic [31:0] word,
                                                      input logic [`XLEN-1:0] pc);
        rv_instr_t         w;
        logic [`UOP_W-1:0] op;
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [31:0]       imm;
        w   = word;
        op  = UOP_ILLEGAL;
        rd  = 5'd0;
        rs1 = 5'd0;
        rs2 = 5'd0;
        imm = 32'd0;
        case (word[6:0])
            7'b0110011: begin
                if (word[14:12] == 3'b000 && word[31:25] == 7'b0000000) op = UOP_ADD;
                if (word[14:12] == 3'b000 && word[31:25] == 7'b0100000) op = UOP_SUB;
            end
            7'b0010011: if (word[14:12] == 3'b000) op = UOP_ADDI;
            7'b0000011: if (word[14:12] == 3'b010) op = UOP_LW;
            7'b0100011: if (word[14:12] == 3'b010) op = UOP_SW;
            7'b1100011: if (word[14:12] == 3'b000) op = UOP_BEQ;
            7'b0110111: op = UOP_LUI;
            7'b1101111: op = UOP_JAL;
            default:    if (word == 32'h0010_0073) op = UOP_EBREAK;
        endcase
        case (op)
            UOP_ADD, UOP_SUB: begin
                rd  = w.r.rd;
                rs1 = w.r.rs1;
                rs2 = w.r.rs2;
            end
            UOP_ADDI, UOP_LW: begin
                rd  = w.i.rd;
                rs1 = w.i.rs1;
                imm = {{20{word[31]}}, word[31:20]};
            end
            UOP_SW: begin
                rs1 = w.s.rs1;
                rs2 = w.s.rs2;
                imm = {{20{word[31]}}, word[31:25], word[11:7]};
            end
            UOP_BEQ: begin
                rs1 = w.b.rs1;
                rs2 = w.b.rs2;
                imm = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
            end
            UOP_LUI: begin
                rd  = w.u.rd;
                imm = {word[31:12], 12'h000};
            end
            UOP_JAL: begin
                rd  = w.j.rd;
                imm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
            end
            default: ;
        endcase
        return {op, rd, rs1, rs2, imm, pc};
    endfunction

    // sel picks the class, r fills the fields.
    function automatic logic [31:0] make_instr(input logic [31:0] sel, input logic [31:0] r);
        case (sel[31:28])
            4'd0: return {7'b0000000, r[24:20], r[19:15], 3'b000, r[11:7], 7'b0110011};
            4'd1: return {7'b0100000, r[24:20], r[19:15], 3'b000, r[11:7], 7'b0110011};
            4'd2: return {r[31:20], r[19:15], 3'b000, r[11:7], 7'b0010011};
            4'd3: return {r[31:20], r[19:15], 3'b010, r[11:7], 7'b0000011};
            4'd4: return {r[31:25], r[24:20], r[19:15], 3'b010, r[11:7], 7'b0100011};
            4'd5: return {r[31:25], r[24:20], r[19:15], 3'b000, r[11:7], 7'b1100011};
            4'd6: return {r[31:12], r[11:7], 7'b0110111};
            4'd7: return {r[31:12], r[11:7], 7'b1101111};
            4'd8: return {7'b0000000, r[24:20], r[19:15], 3'b100, r[11:7], 7'b0110011};
            4'd9: return {r[31:20], r[19:15], 3'b000, r[11:7], 7'b0000011};
            default: return r; // raw word, mostly illegal.
        endcase
    endfunction

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic fail_value(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic tick();
        @(posedge clk);
        if (ready_random) begin
            rng = lcg_next(rng);
            uop_ready <= rng[30];
        end
    endtask

    task automatic random_instr(output logic [31:0] instr);
        logic [31:0] sel;
        rng   = lcg_next(rng);
        sel   = rng;
        rng   = lcg_next(rng);
        instr = make_instr(sel, rng);
    endtask

    // holds the word on the fetch port until taken or max_wait cycles pass.
    task automatic offer(input logic [31:0] instr, input int max_wait, output logic taken);
        int waited;
        taken = 1'b0;
        waited = 0;
        fetch_valid <= 1'b1;
        fetch_pc    <= pc_next;
        fetch_instr <= instr;
        while (!taken && waited < max_wait) begin
            tick();
            taken = fetch_ready;
            waited++;
        end
        if (taken) begin
            pc_next += 32'd4;
        end
    endtask

    task automatic idle_cycle();
        fetch_valid <= 1'b0;
        tick();
    endtask

    task automatic drain();
        ready_random = 1'b0;
        uop_ready <= 1'b1;
        tick();
        while (exp_count != 0) begin
            tick();
        end
    endtask

    task automatic pulse_flush();
        flush <= 1'b1;
        tick();
        flush <= 1'b0;
    endtask

    task automatic random_run(input int n);
        logic [31:0] instr;
        logic        taken;
        for (int i = 0; i < n; i++) begin
            rng = lcg_next(rng);
            if (rng[31:29] == 3'd0) begin
                idle_cycle();
            end
            random_instr(instr);
            offer(instr, 100, taken);
            assert (taken) else fail_value("fetch not accepted under random uop_ready");
        end
        fetch_valid <= 1'b0;
    endtask

    // scoreboard, fed by accepted fetches and emptied by uop handshakes.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (reset || flush) begin
            exp_q.delete();
            stop_seen <= 1'b0;
        end else begin
            if (uop_valid && uop_ready && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            if (fetch_valid && fetch_ready) begin
                exp_q.push_back(expected_uop(fetch_instr, fetch_pc));
                seen_fetch <= 1'b1;
                if (fetch_instr == 32'h0010_0073) begin
                    stop_seen <= 1'b1;
                end
            end
        end
        exp_count <= exp_q.size();
        exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
    end

    always @(posedge clk) begin
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    a_uop_matches: assert property (@(posedge clk) disable iff (reset)
        uop_valid && uop_ready |-> exp_count != 0 && got == exp_head)
        else fail_value($sformatf("uop %h, expected %h (%0d owed)", got, exp_head, exp_count));

    a_idle_after_reset: assert property (@(posedge clk)
        cycles > 0 && !seen_fetch |-> !uop_valid && (!reset || !fetch_ready))
        else fail_value("uop_valid or fetch_ready high before the first fetch");

    a_flush_clears: assert property (@(posedge clk) disable iff (reset)
        flush |=> !uop_valid)
        else fail_value("uop_valid high in the cycle after flush");

    a_fetch_stops: assert property (@(posedge clk) disable iff (reset)
        stop_seen |-> !fetch_ready)
        else fail_value("fetch_ready high after an EBREAK was accepted");

    a_occupancy: assert property (@(posedge clk) disable iff (reset)
        exp_count <= CAP)
        else fail_value($sformatf("%0d uops in flight, limit %0d", exp_count, CAP));

    a_hold_under_backpressure: assert property (@(posedge clk) disable iff (reset)
        uop_valid && !uop_ready && !flush |=> flush || (uop_valid && $stable(got)))
        else fail_value("uop output changed while stalled");

    initial begin
        logic        taken;
        logic [31:0] instr;
        logic [31:0] pending;
        clk          = 1'b0;
        reset        = 1'b1;
        flush        = 1'b0;
        fetch_valid  = 1'b0;
        fetch_pc     = '0;
        fetch_instr  = '0;
        uop_ready    = 1'b0;
        cycles       = 0;
        seen_fetch   = 1'b0;
        stop_seen    = 1'b0;
        exp_count    = 0;
        exp_head     = '0;
        rng          = 32'h2b71;
        pc_next      = 32'h0000_1000;
        ready_random = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        uop_ready <= 1'b1;
        repeat (4) tick();

        ready_random = 1'b1;
        random_run(120);
        drain();

        // back-pressure: only CAP fetches fit while nothing drains.
        uop_ready <= 1'b0;
        for (int i = 0; i < CAP; i++) begin
            random_instr(instr);
            offer(instr, 3, taken);
            assert (taken) else fail_value("fetch refused before the queues were full");
        end
        random_instr(pending);
        offer(pending, 10, taken);
        assert (!taken) else fail_value("fetch accepted beyond queue capacity");
        uop_ready <= 1'b1;
        offer(pending, 50, taken);
        assert (taken) else fail_value("stalled fetch not accepted after release");
        fetch_valid <= 1'b0;
        drain();

        // ebreak stops decode until a flush.
        ready_random = 1'b1;
        random_run(5);
        offer(32'h0010_0073, 100, taken);
        assert (taken) else fail_value("EBREAK not accepted");
        random_instr(pending);
        offer(pending, 20, taken);
        assert (!taken) else fail_value("fetch accepted behind EBREAK");
        drain();
        pulse_flush();
        offer(pending, 20, taken);
        assert (taken) else fail_value("fetch not accepted after flush");
        fetch_valid <= 1'b0;
        drain();

        // flush with uops still queued.
        uop_ready <= 1'b0;
        for (int i = 0; i < 3; i++) begin
            random_instr(instr);
            offer(instr, 3, taken);
            assert (taken) else fail_value("fetch refused before flush");
        end
        fetch_valid <= 1'b0;
        pulse_flush();
        ready_random = 1'b1;
        random_run(40);
        drain();
        repeat (3) tick();

        if (exp_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("%0d expected uops never came out", exp_q.size());
            stop_run();
        end
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
rv_decode_pkg.sv
decode_dispatch.sv
decode_lane.sv
uop_collect.sv
decode_frontend_top.sv
tb_decode_frontend.sv

/* run.sh */
#!/bin/sh
# build the decode front end testbench with Verilator, then run it
verilator --binary --timing --assert -f project.f \
    --top-module tb_decode_frontend -o sim_decode_frontend \
    && ./obj_dir/sim_decode_frontend \
    || exit 1
